//--- src/axil_pkg.sv
package axil_pkg;

   // Bus widths of the AXI-Lite slave port
   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // The two response codes the subsystem produces
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axil_resp_e;

   // Write address channel
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
      logic                   valid;
   } axil_aw_t;

   // Write data channel
   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
      logic                   valid;
   } axil_w_t;

   // Read address channel
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
      logic                   valid;
   } axil_ar_t;

   // Write response channel
   typedef struct packed {
      axil_resp_e resp;
      logic       valid;
   } axil_b_t;

   // Read data channel
   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      axil_resp_e             resp;
      logic                   valid;
   } axil_r_t;

endpackage

//--- src/iob_pkg.sv
package iob_pkg;

   // Native bus carries the same widths as the AXI-Lite side
   localparam int IOB_ADDR_W = axil_pkg::AXIL_ADDR_W;
   localparam int IOB_DATA_W = axil_pkg::AXIL_DATA_W;
   localparam int IOB_STRB_W = IOB_DATA_W / 8;

   // Lowest bit of the 2-bit target field in the address
   localparam int TGT_LSB = 12;

   // Target field values that select a target
   // Field values 2 and 3 are left unmapped
   localparam logic [1:0] MAP_REGS = 2'd0;
   localparam logic [1:0] MAP_RAM  = 2'd1;

   // Nonzero wstrb marks a write
   typedef struct packed {
      logic                  valid;
      logic [IOB_ADDR_W-1:0] addr;
      logic [IOB_DATA_W-1:0] wdata;
      logic [IOB_STRB_W-1:0] wstrb;
   } iob_req_t;

   typedef struct packed {
      logic                  ready;
      logic                  rvalid;
      logic [IOB_DATA_W-1:0] rdata;
      logic                  err;
   } iob_rsp_t;

   typedef enum logic [1:0] {
      TGT_REGS,
      TGT_RAM,
      TGT_NONE
   } iob_target_e;

   function automatic iob_target_e target_of(input logic [IOB_ADDR_W-1:0] addr);
      case (addr[TGT_LSB +: 2])
         MAP_REGS: return TGT_REGS;
         MAP_RAM:  return TGT_RAM;
         default:  return TGT_NONE;
      endcase
   endfunction

endpackage

//--- src/axil2iob.sv
`timescale 1ns/1ps

module axil2iob (
   input  logic               clk,
   input  logic               reset,
   input  axil_pkg::axil_aw_t aw,
   input  axil_pkg::axil_w_t  w,
   input  axil_pkg::axil_ar_t ar,
   output logic               awready,
   output logic               wready,
   output logic               arready,
   output axil_pkg::axil_b_t  b,
   input  logic               bready,
   output axil_pkg::axil_r_t  r,
   input  logic               rready,
   output iob_pkg::iob_req_t  iob_req,
   input  iob_pkg::iob_rsp_t  iob_rsp
);

   typedef enum logic [2:0] {
      IDLE,
      WR_REQ,
      RD_REQ,
      RD_WAIT,
      WR_RESP,
      RD_RESP
   } state_e;

   state_e state;
   state_e state_next;

   // Halves of a write that arrived ahead of the other
   logic aw_held;
   logic w_held;

   logic aw_fire;
   logic w_fire;
   logic ar_fire;
   logic have_aw;
   logic have_w;

   logic [axil_pkg::AXIL_ADDR_W-1:0] waddr_q;
   logic [axil_pkg::AXIL_ADDR_W-1:0] raddr_q;
   logic [axil_pkg::AXIL_DATA_W-1:0] wdata_q;
   logic [axil_pkg::AXIL_STRB_W-1:0] wstrb_q;
   logic [axil_pkg::AXIL_DATA_W-1:0] rdata_q;
   axil_pkg::axil_resp_e             bresp_q;
   axil_pkg::axil_resp_e             rresp_q;

   assign awready = (state == IDLE) && !aw_held;
   assign wready  = (state == IDLE) && !w_held;
   // A complete write takes priority over a read
   assign arready = (state == IDLE) && !aw_held && !w_held && !(aw.valid && w.valid);

   assign aw_fire = aw.valid && awready;
   assign w_fire  = w.valid && wready;
   assign ar_fire = ar.valid && arready;
   assign have_aw = aw_held || aw_fire;
   assign have_w  = w_held || w_fire;

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (have_aw && have_w) begin
               state_next = WR_REQ;
            end else if (ar_fire) begin
               state_next = RD_REQ;
            end
         end
         WR_REQ:  if (iob_rsp.ready) state_next = WR_RESP;
         RD_REQ:  if (iob_rsp.ready) state_next = RD_WAIT;
         RD_WAIT: if (iob_rsp.rvalid) state_next = RD_RESP;
         WR_RESP: if (bready) state_next = IDLE;
         RD_RESP: if (rready) state_next = IDLE;
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end else begin
         state <= state_next;
         if (state == IDLE) begin
            // Both halves go out together, so the flags clear
            aw_held <= have_aw && !have_w;
            w_held  <= have_w && !have_aw;
         end
      end
   end

   // Captured address, data and response payload
   always_ff @(posedge clk) begin
      if (aw_fire) begin
         waddr_q <= aw.addr;
      end
      if (w_fire) begin
         wdata_q <= w.data;
         wstrb_q <= w.strb;
      end
      if (ar_fire) begin
         raddr_q <= ar.addr;
      end
      if (state == WR_REQ && iob_rsp.ready) begin
         bresp_q <= iob_rsp.err ? axil_pkg::SLVERR : axil_pkg::OKAY;
      end
      if (state == RD_WAIT && iob_rsp.rvalid) begin
         rdata_q <= iob_rsp.rdata;
         rresp_q <= iob_rsp.err ? axil_pkg::SLVERR : axil_pkg::OKAY;
      end
   end

   always_comb begin
      iob_req.valid = (state == WR_REQ) || (state == RD_REQ);
      iob_req.addr  = (state == WR_REQ) ? waddr_q : raddr_q;
      iob_req.wdata = wdata_q;
      iob_req.wstrb = (state == WR_REQ) ? wstrb_q : '0;
   end

   always_comb begin
      b.valid = (state == WR_RESP);
      b.resp  = bresp_q;
      r.valid = (state == RD_RESP);
      r.data  = rdata_q;
      r.resp  = rresp_q;
   end

   a_iob_hold: assert property (@(posedge clk) disable iff (reset)
      iob_req.valid && !iob_rsp.ready |=> iob_req.valid && $stable(iob_req.addr));

   a_b_hold: assert property (@(posedge clk) disable iff (reset)
      b.valid && !bready |=> b.valid && $stable(b.resp));

   a_r_hold: assert property (@(posedge clk) disable iff (reset)
      r.valid && !rready |=> r.valid && $stable(r.data));

endmodule

//--- src/iob_decode.sv
`timescale 1ns/1ps

module iob_decode (
   input  logic              clk,
   input  logic              reset,
   input  iob_pkg::iob_req_t req,
   output iob_pkg::iob_rsp_t rsp,
   output iob_pkg::iob_req_t regs_req,
   input  iob_pkg::iob_rsp_t regs_rsp,
   output iob_pkg::iob_req_t ram_req,
   input  iob_pkg::iob_rsp_t ram_rsp
);

   iob_pkg::iob_target_e tgt;
   logic                 none_hit;
   // Accepted read to an unmapped address, answered next cycle
   logic                 none_rd_q;

   assign tgt      = iob_pkg::target_of(req.addr);
   assign none_hit = req.valid && (tgt == iob_pkg::TGT_NONE);

   always_comb begin
      regs_req       = req;
      regs_req.valid = req.valid && (tgt == iob_pkg::TGT_REGS);
      ram_req        = req;
      ram_req.valid  = req.valid && (tgt == iob_pkg::TGT_RAM);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         none_rd_q <= 1'b0;
      end else begin
         none_rd_q <= none_hit && (req.wstrb == '0);
      end
   end

   always_comb begin
      case (tgt)
         iob_pkg::TGT_REGS: rsp.ready = regs_rsp.ready;
         iob_pkg::TGT_RAM:  rsp.ready = ram_rsp.ready;
         default:           rsp.ready = 1'b1;
      endcase

      rsp.rvalid = regs_rsp.rvalid || ram_rsp.rvalid || none_rd_q;

      // Unmapped reads return zero
      if (regs_rsp.rvalid) begin
         rsp.rdata = regs_rsp.rdata;
      end else if (ram_rsp.rvalid) begin
         rsp.rdata = ram_rsp.rdata;
      end else begin
         rsp.rdata = '0;
      end

      rsp.err = none_hit || none_rd_q || regs_rsp.err || ram_rsp.err;
   end

   // Only one target answers a read at a time, so the data merge is safe
   a_one_target: assert property (@(posedge clk) disable iff (reset)
      $onehot0({regs_rsp.rvalid, ram_rsp.rvalid, none_rd_q}));

endmodule

//--- src/iob_reg_bank.sv
`timescale 1ns/1ps

module iob_reg_bank #(
   parameter int N_REGS = 8
) (
   input  logic              clk,
   input  logic              reset,
   input  iob_pkg::iob_req_t req,
   output iob_pkg::iob_rsp_t rsp
);

   localparam int IDX_W = $clog2(N_REGS);
   localparam logic [IDX_W-1:0] CNT_IDX = IDX_W'(N_REGS - 1);

   // Last entry holds the write count
   logic [iob_pkg::IOB_DATA_W-1:0] regs [N_REGS];
   logic [IDX_W-1:0]               idx;
   logic                           wr_en;
   logic                           rd_en;
   logic                           rvalid_q;
   logic [iob_pkg::IOB_DATA_W-1:0] rdata_q;

   // Word address wraps modulo N_REGS
   assign idx   = req.addr[2 +: IDX_W];
   assign wr_en = req.valid && (req.wstrb != '0);
   assign rd_en = req.valid && (req.wstrb == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         if (idx != CNT_IDX) begin
            for (int lane = 0; lane < iob_pkg::IOB_STRB_W; lane++) begin
               if (req.wstrb[lane]) begin
                  regs[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
               end
            end
         end
         // Writes to the counter itself still count
         regs[CNT_IDX] <= regs[CNT_IDX] + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata_q <= regs[idx];
      end
   end

   always_comb begin
      rsp.ready  = 1'b1;
      rsp.rvalid = rvalid_q;
      rsp.rdata  = rdata_q;
      rsp.err    = 1'b0;
   end

endmodule

//--- src/iob_ram.sv
`timescale 1ns/1ps

module iob_ram #(
   parameter int RAM_ADDR_W = 8
) (
   input  logic              clk,
   input  logic              reset,
   input  iob_pkg::iob_req_t req,
   output iob_pkg::iob_rsp_t rsp
);

   localparam int DEPTH = 2 ** RAM_ADDR_W;

   logic [iob_pkg::IOB_DATA_W-1:0] mem [DEPTH];
   logic [RAM_ADDR_W-1:0]          idx;
   logic                           wr_en;
   logic                           rd_en;
   logic                           rvalid_q;
   logic [iob_pkg::IOB_DATA_W-1:0] rdata_q;

   // Word index sits above the byte offset
   assign idx   = req.addr[2 +: RAM_ADDR_W];
   assign wr_en = req.valid && (req.wstrb != '0);
   assign rd_en = req.valid && (req.wstrb == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
         if (wr_en) begin
            for (int lane = 0; lane < iob_pkg::IOB_STRB_W; lane++) begin
               if (req.wstrb[lane]) begin
                  mem[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
               end
            end
         end
         if (rd_en) begin
            rdata_q <= mem[idx];
         end
      end
   end

   always_comb begin
      rsp.ready  = 1'b1;
      rsp.rvalid = rvalid_q;
      rsp.rdata  = rdata_q;
      rsp.err    = 1'b0;
   end

endmodule

//--- src/axil_iob_top.sv
`timescale 1ns/1ps

module axil_iob_top #(
   parameter int N_REGS     = 8,
   parameter int RAM_ADDR_W = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  axil_pkg::axil_aw_t aw,
   input  axil_pkg::axil_w_t  w,
   input  axil_pkg::axil_ar_t ar,
   output logic               awready,
   output logic               wready,
   output logic               arready,
   output axil_pkg::axil_b_t  b,
   input  logic               bready,
   output axil_pkg::axil_r_t  r,
   input  logic               rready
);

   iob_pkg::iob_req_t iob_req;
   iob_pkg::iob_rsp_t iob_rsp;
   iob_pkg::iob_req_t regs_req;
   iob_pkg::iob_rsp_t regs_rsp;
   iob_pkg::iob_req_t ram_req;
   iob_pkg::iob_rsp_t ram_rsp;

   axil2iob axil2iob_i (
      .clk     (clk),
      .reset   (reset),
      .aw      (aw),
      .w       (w),
      .ar      (ar),
      .awready (awready),
      .wready  (wready),
      .arready (arready),
      .b       (b),
      .bready  (bready),
      .r       (r),
      .rready  (rready),
      .iob_req (iob_req),
      .iob_rsp (iob_rsp)
   );

   iob_decode iob_decode_i (
      .clk      (clk),
      .reset    (reset),
      .req      (iob_req),
      .rsp      (iob_rsp),
      .regs_req (regs_req),
      .regs_rsp (regs_rsp),
      .ram_req  (ram_req),
      .ram_rsp  (ram_rsp)
   );

   iob_reg_bank #(.N_REGS(N_REGS)) iob_reg_bank_i (
      .clk   (clk),
      .reset (reset),
      .req   (regs_req),
      .rsp   (regs_rsp)
   );

   iob_ram #(.RAM_ADDR_W(RAM_ADDR_W)) iob_ram_i (
      .clk   (clk),
      .reset (reset),
      .req   (ram_req),
      .rsp   (ram_rsp)
   );

endmodule

//--- test/axil_iob_tb.sv
`timescale 1ns/1ps

module axil_iob_tb;

   localparam int N_REGS     = 8;
   localparam int RAM_ADDR_W = 8;
   localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;
   localparam int CLK_PERIOD = 20;
   localparam int N_RAM_WR   = 100;
   localparam int N_BP       = 10;
   // Register pass, RAM pass, counter, unmapped, ordering, back-pressure
   localparam int N_TRANS = 3 * (N_REGS - 1) + N_RAM_WR + RAM_DEPTH + 3 + 6 + 6 + 2 * N_BP;
   localparam int CYCLES_PER_TRANS = 50;

   // Order of the AW and W halves of a write
   localparam int BOTH     = 0;
   localparam int AW_FIRST = 1;
   localparam int W_FIRST  = 2;

   logic               clk;
   logic               reset;
   axil_pkg::axil_aw_t aw;
   axil_pkg::axil_w_t  w;
   axil_pkg::axil_ar_t ar;
   logic               awready;
   logic               wready;
   logic               arready;
   axil_pkg::axil_b_t  b;
   logic               bready;
   axil_pkg::axil_r_t  r;
   logic               rready;

   // Shadow copies of the DUT storage
   logic [31:0] reg_model [N_REGS];
   logic [31:0] ram_model [RAM_DEPTH];
   logic [31:0] wr_count;

   // Expected responses in issue order
   logic [1:0]  exp_b_q [$];
   logic [33:0] exp_r_q [$];
   string       test_name;
   int unsigned bp_max;
   int unsigned seed;

   axil_iob_top axil_iob_top_i (
      .clk     (clk),
      .reset   (reset),
      .aw      (aw),
      .w       (w),
      .ar      (ar),
      .awready (awready),
      .wready  (wready),
      .arready (arready),
      .b       (b),
      .bready  (bready),
      .r       (r),
      .rready  (rready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual) begin
         $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
         $display("Test failures found");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "Stopped on error");
   endtask

   // Byte lane writes into the shadow arrays, counting register bank writes
   task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      int unsigned idx;
      case (addr[iob_pkg::TGT_LSB +: 2])
         2'd0: begin
            idx = (addr >> 2) % N_REGS;
            for (int lane = 0; lane < 4; lane++) begin
               if (strb[lane] && idx != N_REGS - 1) begin
                  reg_model[idx][8*lane +: 8] = data[8*lane +: 8];
               end
            end
            wr_count = wr_count + 1;
         end
         2'd1: begin
            idx = (addr >> 2) % RAM_DEPTH;
            for (int lane = 0; lane < 4; lane++) begin
               if (strb[lane]) begin
                  ram_model[idx][8*lane +: 8] = data[8*lane +: 8];
               end
            end
         end
         default: begin
         end
      endcase
   endtask

   // Expected read data in the upper bits, response code in the low two
   function automatic logic [33:0] exp_read(input logic [31:0] addr);
      int unsigned idx;
      case (addr[iob_pkg::TGT_LSB +: 2])
         2'd0: begin
            idx = (addr >> 2) % N_REGS;
            if (idx == N_REGS - 1) begin
               return {wr_count, axil_pkg::OKAY};
            end
            return {reg_model[idx], axil_pkg::OKAY};
         end
         2'd1: return {ram_model[(addr >> 2) % RAM_DEPTH], axil_pkg::OKAY};
         default: return {32'h0, axil_pkg::SLVERR};
      endcase
   endfunction

   function automatic logic [1:0] exp_wresp(input logic [31:0] addr);
      if (addr[iob_pkg::TGT_LSB +: 2] < 2'd2) begin
         return axil_pkg::OKAY;
      end
      return axil_pkg::SLVERR;
   endfunction

   function automatic logic [63:0] rsp_bits(input bit is_read);
      logic [63:0] val;
      if (is_read) begin
         val = r;
      end else begin
         val = b;
      end
      return val;
   endfunction

   // Waits for bvalid or rvalid, stalling ready for a random number of cycles
   task automatic collect_rsp(input bit is_read);
      logic [63:0] first;
      int unsigned hold;
      hold = (bp_max == 0) ? 0 : $urandom_range(bp_max, 1);
      if (is_read) begin
         rready = (hold == 0);
      end else begin
         bready = (hold == 0);
      end
      @(posedge clk);
      while (!(is_read ? r.valid : b.valid)) begin
         @(posedge clk);
      end
      first = rsp_bits(is_read);
      // No new address is taken while a response is pending
      check({test_name, " readies during response"}, 64'h0, {awready, wready, arready});
      if (hold != 0) begin
         repeat (hold) begin
            @(posedge clk);
            check({test_name, " held response"}, first, rsp_bits(is_read));
            check({test_name, " readies during stall"}, 64'h0,
                  {awready, wready, arready});
         end
         #1;
         if (is_read) begin
            rready = 1'b1;
         end else begin
            bready = 1'b1;
         end
         @(posedge clk);
      end
      #1;
      bready = 1'b0;
      rready = 1'b0;
   endtask

   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int order);
      bit aw_done;
      bit w_done;
      exp_b_q.push_back(exp_wresp(addr));
      model_write(addr, data, strb);
      aw_done  = 1'b0;
      w_done   = 1'b0;
      aw.addr  = addr;
      w.data   = data;
      w.strb   = strb;
      aw.valid = (order != W_FIRST);
      w.valid  = (order != AW_FIRST);
      while (!(aw_done && w_done)) begin
         @(posedge clk);
         if (aw.valid && awready) begin
            aw_done = 1'b1;
         end
         if (w.valid && wready) begin
            w_done = 1'b1;
         end
         #1;
         // Second half follows once the first is taken
         aw.valid = !aw_done && (w_done || order != W_FIRST);
         w.valid  = !w_done && (aw_done || order != AW_FIRST);
      end
      collect_rsp(1'b0);
   endtask

   task automatic axil_read(input logic [31:0] addr);
      exp_r_q.push_back(exp_read(addr));
      ar.addr  = addr;
      ar.valid = 1'b1;
      @(posedge clk);
      while (!arready) begin
         @(posedge clk);
      end
      #1;
      ar.valid = 1'b0;
      collect_rsp(1'b1);
   endtask

   // Compares every completed response with the queued expectation
   always @(posedge clk) begin
      if (!reset && b.valid && bready) begin
         if (exp_b_q.size() == 0) begin
            stop_run("Write response arrived with no write outstanding");
         end else begin
            check({test_name, " bresp"}, exp_b_q.pop_front(), b.resp);
         end
      end
      if (!reset && r.valid && rready) begin
         if (exp_r_q.size() == 0) begin
            stop_run("Read response arrived with no read outstanding");
         end else begin
            check({test_name, " rdata/rresp"}, exp_r_q.pop_front(), {r.data, r.resp});
         end
      end
   end

   task automatic reg_bank_rw();
      logic [31:0] addr;
      test_name = "reg_bank";
      for (int i = 0; i < N_REGS - 1; i++) begin
         addr = 32'(i * 4);
         axil_write(addr, $urandom, 4'hf, BOTH);
         axil_write(addr, $urandom, 4'($urandom_range(14, 1)), BOTH);
         axil_read(addr);
      end
   endtask

   task automatic ram_random_rw();
      logic [31:0] base;
      logic [31:0] offs;
      test_name = "ram";
      base = 32'h1 << iob_pkg::TGT_LSB;
      for (int i = 0; i < N_RAM_WR; i++) begin
         offs = 32'($urandom_range(RAM_DEPTH - 1, 0)) << 2;
         axil_write(base | offs, $urandom, 4'($urandom_range(15, 1)), BOTH);
      end
      // Full sweep also covers words never written
      for (int i = 0; i < RAM_DEPTH; i++) begin
         axil_read(base | (32'(i) << 2));
      end
   endtask

   task automatic write_counter();
      logic [31:0] cnt_addr;
      test_name = "write_counter";
      cnt_addr = 32'((N_REGS - 1) * 4);
      axil_read(cnt_addr);
      axil_write(cnt_addr, 32'hdead_beef, 4'hf, BOTH);
      axil_read(cnt_addr);
   endtask

   task automatic unmapped_targets();
      test_name = "unmapped";
      for (int f = 2; f < 4; f++) begin
         axil_write((32'(f) << iob_pkg::TGT_LSB) | 32'h10, $urandom, 4'hf, BOTH);
         axil_read((32'(f) << iob_pkg::TGT_LSB) | 32'h14);
      end
      test_name = "after_unmapped";
      axil_read(32'h0);
      axil_read(32'h1 << iob_pkg::TGT_LSB);
   endtask

   // Distinct data per order so a stale data latch shows up
   task automatic channel_ordering();
      test_name = "ordering";
      axil_write(32'h4, $urandom, 4'hf, BOTH);
      axil_write(32'h8, $urandom, 4'hf, AW_FIRST);
      axil_write(32'hc, $urandom, 4'hf, W_FIRST);
      axil_read(32'h4);
      axil_read(32'h8);
      axil_read(32'hc);
   endtask

   task automatic response_backpressure();
      logic [31:0] addr;
      test_name = "backpressure";
      bp_max = 6;
      for (int i = 0; i < N_BP; i++) begin
         if (i % 2 == 0) begin
            addr = 32'($urandom_range(N_REGS - 2, 0)) << 2;
         end else begin
            addr = (32'h1 << iob_pkg::TGT_LSB) | (32'($urandom_range(RAM_DEPTH - 1, 0)) << 2);
         end
         axil_write(addr, $urandom, 4'($urandom_range(15, 1)), BOTH);
         axil_read(addr);
      end
      bp_max = 0;
   endtask

   initial begin
      seed = 32'h632d;
      void'($urandom(seed));
      reset     = 1'b1;
      aw        = '0;
      w         = '0;
      ar        = '0;
      bready    = 1'b0;
      rready    = 1'b0;
      bp_max    = 0;
      wr_count  = '0;
      test_name = "reset";
      for (int i = 0; i < N_REGS; i++) begin
         reg_model[i] = '0;
      end
      for (int i = 0; i < RAM_DEPTH; i++) begin
         ram_model[i] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      check({test_name, " readies"}, 64'h7, {awready, wready, arready});

      reg_bank_rw();
      ram_random_rw();
      write_counter();
      unmapped_targets();
      channel_ordering();
      response_backpressure();

      if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
         $display("Run ended with responses still outstanding");
         $display("Test failures found");
         $fatal(1, "Missing responses");
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

   // Generous per-transaction budget
   initial begin
      repeat (N_TRANS * CYCLES_PER_TRANS) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles",
               N_TRANS * CYCLES_PER_TRANS);
      $display("Test failures found");
      $fatal(1, "Watchdog expired");
   end

endmodule

//--- compile.f
src/axil_pkg.sv
src/iob_pkg.sv
src/axil2iob.sv
src/iob_decode.sv
src/iob_reg_bank.sv
src/iob_ram.sv
src/axil_iob_top.sv
test/axil_iob_tb.sv
